/* logic/cpu_types_pkg.sv */
// ----------------------------------------------------------
// shared types for the APB driven MIPS execution unit
// opcodes, function codes, ALU ops, instruction union,
// control / result structs and the APB register map
// ----------------------------------------------------------
`default_nettype none

package cpu_types_pkg;

   // register map and sizes
   localparam int REG_COUNT  = 32;
   localparam int DMEM_WORDS = 64;
   localparam int REG_AW     = $clog2(REG_COUNT);
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);
   localparam int APB_ADDR_W = 12;

   localparam logic [APB_ADDR_W-1:0] ADDR_CMD    = 12'h000;
   localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h004;
   localparam logic [APB_ADDR_W-1:0] REG_BASE    = 12'h080;
   localparam logic [APB_ADDR_W-1:0] DMEM_BASE   = 12'h100;
   localparam logic [APB_ADDR_W-1:0] DMEM_LIMIT  = 12'h200; // first address past dmem

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010, // no pc here, decoded as nop
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      SLTIU = 6'b001011,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = 6'b111111
   } opcode_t;

   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      JR   = 6'b001000, // nop as well
      ADD  = 6'b100000,
      ADDU = 6'b100001,
      SUB  = 6'b100010,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU
   } aluop_t;

   typedef enum logic [1:0] {
      SRC_REG, // rt
      SRC_IMM, // extended imm16
      SRC_LUI  // imm16 in upper half
   } alusrc_t;

   typedef struct packed {
      opcode_t    op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_t     funct;
   } instr_r_t;

   typedef struct packed {
      opcode_t     op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
   } instr_i_t;

   // one instruction word, two field layouts
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef struct packed {
      logic   valid;
      instr_u instr;
   } issue_t;

   typedef struct packed {
      aluop_t  alu_op;
      alusrc_t alu_src;
      logic    extop;    // 1 = sign extend
      logic    regdst;   // 1 = dest is rt
      logic    regwr;
      logic    memwr;
      logic    memtoreg;
      logic    is_beq;
      logic    is_bne;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      logic [31:0] alu_result;
      logic [31:0] store_data;
      logic [4:0]  dest;
      logic        branch_taken;
   } exec_t;

   typedef struct packed {
      logic        en;
      logic [4:0]  addr;
      logic [31:0] data;
   } reg_wr_t;

   // bit 1 branch_taken, bit 0 halted
   typedef struct packed {
      logic branch_taken;
      logic halted;
   } status_t;

endpackage

`default_nettype wire

/* logic/apb_host_port.sv */
// ----------------------------------------------------------
// APB slave front end, zero wait states
// address decode, instruction issue, host register writes
// and read data mux
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [cpu_types_pkg::APB_ADDR_W-1:0]  paddr,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [31:0]                           pwdata,
   output logic [31:0]                           prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   output cpu_types_pkg::issue_t                 issue,
   output cpu_types_pkg::reg_wr_t                host_wr,
   output logic [cpu_types_pkg::REG_AW-1:0]      reg_rd_addr,
   input  logic [31:0]                           reg_rd_data,
   output logic [cpu_types_pkg::DMEM_AW-1:0]     dmem_rd_addr,
   input  logic [31:0]                           dmem_rd_data,
   input  cpu_types_pkg::status_t                status
);
   import cpu_types_pkg::*;

   logic   access;     // second cycle of a transfer
   logic   aligned;
   logic   is_cmd;
   logic   is_status;
   logic   is_reg;
   logic   is_dmem;
   logic   cmd_ok;     // accepted instruction write
   logic   wr_ok;
   logic   rd_ok;
   logic   issue_valid;
   instr_u issue_instr;

   assign access  = psel & penable;
   assign aligned = (paddr[1:0] == 2'b00);

   // address map decode
   assign is_cmd    = (paddr == ADDR_CMD);
   assign is_status = (paddr == ADDR_STATUS);
   assign is_reg    = aligned && (paddr >= REG_BASE) && (paddr < DMEM_BASE);
   assign is_dmem   = aligned && (paddr >= DMEM_BASE) && (paddr < DMEM_LIMIT);

   // word index inside each window
   assign reg_rd_addr  = paddr[REG_AW+1:2];
   assign dmem_rd_addr = paddr[DMEM_AW+1:2];

   assign cmd_ok = access & pwrite & is_cmd & ~status.halted; // refused once halted
   assign wr_ok  = is_reg | (is_cmd & ~status.halted);
   assign rd_ok  = is_status | is_reg | is_dmem;

   assign pready  = 1'b1; // no wait states
   assign pslverr = access & (pwrite ? ~wr_ok : ~rd_ok);

   // host register write lands on the access edge
   assign host_wr = '{en: access & pwrite & is_reg, addr: reg_rd_addr, data: pwdata};

   // issue pulse, one cycle after the access edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= cmd_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_ok) begin
         issue_instr <= instr_u'(pwdata); // held until the next command
      end
   end

   assign issue = '{valid: issue_valid, instr: issue_instr};

   // read data mux
   always_comb begin
      prdata = '0;
      if (is_status) begin
         prdata = {30'd0, status};
      end else if (is_reg) begin
         prdata = reg_rd_data;
      end else if (is_dmem) begin
         prdata = dmem_rd_data;
      end
   end

endmodule

`default_nettype wire

/* logic/control_unit.sv */
// ----------------------------------------------------------
// instruction decode into the control struct
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_unit (
   input  cpu_types_pkg::instr_u instr,
   output cpu_types_pkg::ctrl_t  ctrl
);
   import cpu_types_pkg::*;

   opcode_t op;
   funct_t  funct;

   assign op    = instr.r.op;    // same bits in both views
   assign funct = instr.r.funct;

   always_comb begin
      // default is a nop, no side effects
      ctrl          = '0;
      ctrl.alu_op   = ALU_ADD;
      ctrl.alu_src  = SRC_REG;
      ctrl.extop    = 1'b1;
      ctrl.regdst   = 1'b1;

      case (op)
         RTYPE: begin
            ctrl.regdst = 1'b0; // write rd
            ctrl.regwr  = 1'b1;
            case (funct)
               ADD, ADDU: ctrl.alu_op = ALU_ADD;
               SUB, SUBU: ctrl.alu_op = ALU_SUB;
               AND:       ctrl.alu_op = ALU_AND;
               OR:        ctrl.alu_op = ALU_OR;
               XOR:       ctrl.alu_op = ALU_XOR;
               NOR:       ctrl.alu_op = ALU_NOR;
               SLL:       ctrl.alu_op = ALU_SLL;
               SRL:       ctrl.alu_op = ALU_SRL;
               SLT:       ctrl.alu_op = ALU_SLT;
               SLTU:      ctrl.alu_op = ALU_SLTU;
               default:   ctrl.regwr  = 1'b0; // JR and unknown
            endcase
         end
         ADDIU, SLTI, SLTIU: begin
            ctrl.alu_src = SRC_IMM;         // sign extended
            ctrl.regwr   = 1'b1;
            if (op == SLTI) begin
               ctrl.alu_op = ALU_SLT;
            end else if (op == SLTIU) begin
               ctrl.alu_op = ALU_SLTU;      // sign extend, unsigned compare
            end
         end
         ANDI, ORI, XORI: begin
            ctrl.alu_src = SRC_IMM;
            ctrl.extop   = 1'b0;            // logic ops zero extend
            ctrl.regwr   = 1'b1;
            ctrl.alu_op  = (op == ANDI) ? ALU_AND :
                           (op == ORI)  ? ALU_OR  : ALU_XOR;
         end
         LUI: begin
            ctrl.alu_src = SRC_LUI;
            ctrl.extop   = 1'b0;
            ctrl.alu_op  = ALU_OR;          // 0 | {imm16, 16'h0}
            ctrl.regwr   = 1'b1;
         end
         LW: begin
            ctrl.alu_src  = SRC_IMM;        // base + offset
            ctrl.regwr    = 1'b1;
            ctrl.memtoreg = 1'b1;
         end
         SW: begin
            ctrl.alu_src = SRC_IMM;
            ctrl.memwr   = 1'b1;
         end
         BEQ: begin
            ctrl.alu_op = ALU_SUB;          // zero on equal
            ctrl.is_beq = 1'b1;
         end
         BNE: begin
            ctrl.alu_op = ALU_SUB;
            ctrl.is_bne = 1'b1;
         end
         HALT:    ctrl.halt = 1'b1;
         default: ;                         // J and unknown opcodes
      endcase
   end

endmodule

`default_nettype wire

/* logic/register_file.sv */
// ----------------------------------------------------------
// 32 x 32 register file, r0 fixed at zero
// two instruction read ports, one host read port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [cpu_types_pkg::REG_AW-1:0]  rs_addr,
   input  logic [cpu_types_pkg::REG_AW-1:0]  rt_addr,
   output logic [31:0]                       rs_data,
   output logic [31:0]                       rt_data,
   input  logic [cpu_types_pkg::REG_AW-1:0]  host_rd_addr,
   output logic [31:0]                       host_rd_data,
   input  cpu_types_pkg::reg_wr_t            wr_inst,
   input  cpu_types_pkg::reg_wr_t            wr_host
);
   import cpu_types_pkg::*;

   logic [31:0] regs [REG_COUNT];
   reg_wr_t     wr;

   // requests never overlap, instruction side first anyway
   assign wr = wr_inst.en ? wr_inst : wr_host;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en && (wr.addr != '0)) begin
         regs[wr.addr] <= wr.data; // r0 never written, stays zero
      end
   end

   assign rs_data      = regs[rs_addr];
   assign rt_data      = regs[rt_addr];
   assign host_rd_data = regs[host_rd_addr];

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// ----------------------------------------------------------
// operand select, immediate extension, ALU, branch decision
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  cpu_types_pkg::issue_t             issue,
   input  cpu_types_pkg::ctrl_t              ctrl,
   output logic [cpu_types_pkg::REG_AW-1:0]  rs_addr,
   output logic [cpu_types_pkg::REG_AW-1:0]  rt_addr,
   input  logic [31:0]                       rs_data,
   input  logic [31:0]                       rt_data,
   output cpu_types_pkg::exec_t              ex
);
   import cpu_types_pkg::*;

   logic [31:0] imm_ext;
   logic [31:0] a_op;
   logic [31:0] b_op;
   logic [4:0]  shamt;
   logic [31:0] result;
   logic        zero;

   assign rs_addr = issue.instr.r.rs;
   assign rt_addr = issue.instr.r.rt;
   assign shamt   = issue.instr.r.shamt;

   assign imm_ext = ctrl.extop ? {{16{issue.instr.i.imm16[15]}}, issue.instr.i.imm16}
                               : {16'h0000, issue.instr.i.imm16};

   // LUI ignores rs
   assign a_op = (ctrl.alu_src == SRC_LUI) ? '0 : rs_data;

   always_comb begin
      case (ctrl.alu_src)
         SRC_IMM: b_op = imm_ext;
         SRC_LUI: b_op = {issue.instr.i.imm16, 16'h0000};
         default: b_op = rt_data;
      endcase
   end

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD:  result = a_op + b_op;
         ALU_SUB:  result = a_op - b_op;
         ALU_AND:  result = a_op & b_op;
         ALU_OR:   result = a_op | b_op;
         ALU_XOR:  result = a_op ^ b_op;
         ALU_NOR:  result = ~(a_op | b_op);
         ALU_SLL:  result = b_op << shamt;    // shifts work on rt
         ALU_SRL:  result = b_op >> shamt;
         ALU_SLT:  result = {31'd0, $signed(a_op) < $signed(b_op)};
         ALU_SLTU: result = {31'd0, a_op < b_op};
         default:  result = a_op + b_op;
      endcase
   end

   assign zero = (result == '0);

   assign ex.valid        = issue.valid;
   assign ex.ctrl         = ctrl;
   assign ex.alu_result   = result;
   assign ex.store_data   = rt_data;                       // SW data
   assign ex.dest         = ctrl.regdst ? issue.instr.i.rt : issue.instr.r.rd;
   assign ex.branch_taken = (ctrl.is_beq & zero) | (ctrl.is_bne & ~zero);

endmodule

`default_nettype wire

/* logic/result_stage.sv */
// ----------------------------------------------------------
// data memory, write-back select, status flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module result_stage (
   input  logic                               clk,
   input  logic                               rst_n,
   input  cpu_types_pkg::exec_t               ex,
   output cpu_types_pkg::reg_wr_t             inst_wr,
   input  logic [cpu_types_pkg::DMEM_AW-1:0]  dmem_rd_addr,
   output logic [31:0]                        dmem_rd_data,
   output cpu_types_pkg::status_t             status
);
   import cpu_types_pkg::*;

   logic [31:0]        dmem [DMEM_WORDS];
   logic [DMEM_AW-1:0] mem_idx;
   logic               mem_wr;
   logic               is_branch;

   assign mem_idx   = ex.alu_result[DMEM_AW+1:2]; // word address, wraps at 64
   assign mem_wr    = ex.valid & ex.ctrl.memwr;
   assign is_branch = ex.ctrl.is_beq | ex.ctrl.is_bne;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (mem_wr) begin
         dmem[mem_idx] <= ex.store_data;
      end
   end

   // write-back, taken at the end of the issue cycle
   assign inst_wr.en   = ex.valid & ex.ctrl.regwr;
   assign inst_wr.addr = ex.dest;
   assign inst_wr.data = ex.ctrl.memtoreg ? dmem[mem_idx] : ex.alu_result;

   assign dmem_rd_data = dmem[dmem_rd_addr]; // host read port

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         status <= '0;
      end else if (ex.valid) begin
         if (ex.ctrl.halt) begin
            status.halted <= 1'b1; // sticky until reset
         end
         if (is_branch) begin
            status.branch_taken <= ex.branch_taken;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/cpu_exec_top.sv */
// ----------------------------------------------------------
// top level of the execution unit, APB slave ports
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_top (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [cpu_types_pkg::APB_ADDR_W-1:0]  paddr,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [31:0]                           pwdata,
   output logic [31:0]                           prdata,
   output logic                                  pready,
   output logic                                  pslverr
);
   import cpu_types_pkg::*;

   issue_t             issue;
   ctrl_t              ctrl;
   exec_t              ex;
   reg_wr_t            host_wr;
   reg_wr_t            inst_wr;
   status_t            status;
   logic [REG_AW-1:0]  rs_addr;
   logic [REG_AW-1:0]  rt_addr;
   logic [REG_AW-1:0]  reg_rd_addr;
   logic [31:0]        rs_data;
   logic [31:0]        rt_data;
   logic [31:0]        reg_rd_data;
   logic [DMEM_AW-1:0] dmem_rd_addr;
   logic [31:0]        dmem_rd_data;

   apb_host_port i_apb_host_port (
      .clk, .rst_n,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .issue, .host_wr,
      .reg_rd_addr, .reg_rd_data,
      .dmem_rd_addr, .dmem_rd_data,
      .status
   );

   control_unit i_control_unit (
      .instr (issue.instr),
      .ctrl
   );

   register_file i_register_file (
      .clk, .rst_n,
      .rs_addr, .rt_addr, .rs_data, .rt_data,
      .host_rd_addr (reg_rd_addr),
      .host_rd_data (reg_rd_data),
      .wr_inst      (inst_wr),
      .wr_host      (host_wr)
   );

   execute_stage i_execute_stage (
      .issue, .ctrl,
      .rs_addr, .rt_addr, .rs_data, .rt_data,
      .ex
   );

   result_stage i_result_stage (
      .clk, .rst_n,
      .ex, .inst_wr,
      .dmem_rd_addr, .dmem_rd_data,
      .status
   );

endmodule

`default_nettype wire

/* verification/cpu_exec_assertions.sv */
// ----------------------------------------------------------
// concurrent checks on APB port, write ports, halt flag
// bound into cpu_exec_top
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_assertions (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   pready,
   input cpu_types_pkg::issue_t  issue,
   input cpu_types_pkg::reg_wr_t inst_wr,
   input cpu_types_pkg::reg_wr_t host_wr,
   input cpu_types_pkg::status_t status
);

   // zero wait state slave
   a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
      else $error("pready went low");

   // issue is a single cycle pulse
   a_issue_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      issue.valid |=> !issue.valid)
      else $error("issue valid held longer than one cycle");

   a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
      !(inst_wr.en && host_wr.en))
      else $error("instruction and host register writes in the same cycle");

   // only reset clears halted
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      status.halted |=> status.halted)
      else $error("halted cleared without reset");

endmodule

bind cpu_exec_top cpu_exec_assertions i_cpu_exec_assertions (
   .clk, .rst_n, .pready, .issue, .inst_wr, .host_wr, .status
);

`default_nettype wire

/* verification/cpu_exec_tb.sv */
// ----------------------------------------------------------
// testbench for the APB driven MIPS execution unit
// clock, reset, LFSR stimulus, APB tasks, reference model,
// checks, watchdog and summary
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_tb;
   import cpu_types_pkg::*;

   localparam int ALU_COUNT = 300;
   localparam int MEM_COUNT = 60;
   localparam int BR_COUNT  = 60;
   // apb transfers over the whole run
   localparam int NUM_OPS   = 2 * REG_COUNT + 2 * ALU_COUNT + 3 * MEM_COUNT
                              + DMEM_WORDS + 3 * BR_COUNT + 20;

   logic                  clk;
   logic                  rst_n;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pready;
   logic                  pslverr;

   logic [31:0] lfsr;
   logic [31:0] model_regs [REG_COUNT]; // reference state
   logic [31:0] model_mem [DMEM_WORDS];
   logic        model_halted;
   logic        model_branch;
   int          checks;
   int          value_errors;
   int          other_errors;
   int          monitor_errors = 0;
   logic        prev_valid     = 1'b0;
   logic        prev_halted    = 1'b0;

   logic [5:0] alu_functs [12] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLL, SRL, SLT, SLTU};
   logic [5:0] alu_iops [7]    = '{ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI};

   cpu_exec_top i_cpu_exec_top (
      .clk, .rst_n,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]}; // one step per bit
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   function automatic logic [31:0] sext(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   // reference model for one instruction word
   function automatic void model_exec(input logic [31:0] w);
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [31:0] res;
      logic        wr_en;
      logic [4:0]  wr_addr;
      op      = w[31:26];
      rs      = w[25:21];
      rt      = w[20:16];
      imm     = w[15:0];
      a       = model_regs[rs];
      b       = model_regs[rt];
      addr    = a + sext(imm);           // lw/sw effective address
      res     = '0;
      wr_en   = 1'b1;
      wr_addr = rt;                      // i-type target
      case (op)
         RTYPE: begin
            wr_addr = w[15:11];
            case (w[5:0])
               ADD, ADDU: res = a + b;
               SUB, SUBU: res = a - b;
               AND:       res = a & b;
               OR:        res = a | b;
               XOR:       res = a ^ b;
               NOR:       res = ~(a | b);
               SLL:       res = b << w[10:6];
               SRL:       res = b >> w[10:6];
               SLT:       res = {31'd0, $signed(a) < $signed(b)};
               SLTU:      res = {31'd0, a < b};
               default:   wr_en = 1'b0;
            endcase
         end
         ADDIU:   res = a + sext(imm);
         SLTI:    res = {31'd0, $signed(a) < $signed(sext(imm))};
         SLTIU:   res = {31'd0, a < sext(imm)};   // sign extended imm in an unsigned compare
         ANDI:    res = a & {16'h0000, imm};
         ORI:     res = a | {16'h0000, imm};
         XORI:    res = a ^ {16'h0000, imm};
         LUI:     res = {imm, 16'h0000};
         LW:      res = model_mem[addr[7:2]];
         default: begin
            wr_en = 1'b0;
            if (op == SW) model_mem[addr[7:2]] = b;
            if (op == BEQ) model_branch = (a == b);
            if (op == BNE) model_branch = (a != b);
            if (op == HALT) model_halted = 1'b1;
         end
      endcase
      if (wr_en && wr_addr != 5'd0) begin
         model_regs[wr_addr] = res;      // r0 stays zero
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         value_errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // setup phase 1 ns after the edge and sample just before the access edge
   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      #1;
      err = pslverr;
      @(posedge clk);                    // access edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      #1;
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic host_write_reg(input logic [4:0] n, input logic [31:0] data);
      logic err;
      apb_write(REG_BASE + {5'd0, n, 2'b00}, data, err);
      check_value("pslverr", {31'd0, err}, 32'd0);
      if (n != 5'd0) model_regs[n] = data;
   endtask

   task automatic check_reg(input logic [4:0] n);
      logic [31:0] d;
      logic        err;
      apb_read(REG_BASE + {5'd0, n, 2'b00}, d, err);
      check_value("pslverr", {31'd0, err}, 32'd0);
      check_value($sformatf("r%0d", n), d, model_regs[n]);
   endtask

   task automatic check_status();
      logic [31:0] d;
      logic        err;
      apb_read(ADDR_STATUS, d, err);
      check_value("pslverr", {31'd0, err}, 32'd0);
      check_value("status", d, {30'd0, model_branch, model_halted});
   endtask

   task automatic check_dmem(input logic [5:0] idx);
      logic [31:0] d;
      logic        err;
      apb_read(DMEM_BASE + {4'd0, idx, 2'b00}, d, err);
      check_value("pslverr", {31'd0, err}, 32'd0);
      check_value($sformatf("dmem[%0d]", idx), d, model_mem[idx]);
   endtask

   // command write that is refused once halted
   task automatic run_instr(input logic [31:0] instr);
      logic err;
      apb_write(ADDR_CMD, instr, err);
      check_value("pslverr", {31'd0, err}, {31'd0, model_halted});
      if (!model_halted) model_exec(instr);
   endtask

   // monitor of pready, issue pulse, write port overlap and halted
   always @(negedge clk) begin
      if (rst_n) begin
         if (pready !== 1'b1) begin
            monitor_errors++;
            $display("error at %0t: pready is %b, expected 1", $time, pready);
         end
         if (i_cpu_exec_top.issue.valid && prev_valid) begin
            monitor_errors++;
            $display("issue valid lasted more than one cycle at %0t", $time);
         end
         if (i_cpu_exec_top.inst_wr.en && i_cpu_exec_top.host_wr.en) begin
            monitor_errors++;
            $display("both register write requests enabled at %0t", $time);
         end
         if (prev_halted && !i_cpu_exec_top.status.halted) begin
            monitor_errors++;
            $display("halted cleared without reset at %0t", $time);
         end
      end
      prev_valid  = i_cpu_exec_top.issue.valid;
      prev_halted = i_cpu_exec_top.status.halted;
   end

   // watchdog
   initial begin
      repeat (NUM_OPS * 30) @(posedge clk);
      $display("timeout: stimulus did not finish within %0d cycles", NUM_OPS * 30);
      $display("Test failed");
      $finish;
   end

   initial begin
      logic [31:0] w;
      logic [31:0] d;
      logic        err;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  dest;
      logic [5:0]  op;
      logic [15:0] imm;
      logic [5:0]  base_w;
      logic [5:0]  off_w;
      lfsr         = 32'h27edec99;
      rst_n        = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      checks       = 0;
      value_errors = 0;
      other_errors = 0;
      model_halted = 1'b0;
      model_branch = 1'b0;
      foreach (model_regs[i]) model_regs[i] = '0;
      foreach (model_mem[i]) model_mem[i] = '0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_status();                    // all clear after reset

      // seed every register and expect the r0 write dropped
      for (int n = 0; n < REG_COUNT; n++) host_write_reg(5'(n), rand_bits(32));
      for (int n = 0; n < REG_COUNT; n++) check_reg(5'(n));

      // random r-type and i-type alu instructions
      for (int k = 0; k < ALU_COUNT; k++) begin
         rs  = 5'(rand_bits(5));
         rt  = 5'(rand_bits(5));
         rd  = 5'(rand_bits(5));
         imm = 16'(rand_bits(16));
         if (rand_bits(1) == 32'd1) begin
            w    = {RTYPE, rs, rt, rd, 5'(rand_bits(5)), alu_functs[int'(rand_bits(4) % 12)]};
            dest = rd;
         end else begin
            w    = {alu_iops[int'(rand_bits(3) % 7)], rs, rt, imm};
            dest = rt;
         end
         run_instr(w);
         check_reg(dest);
      end

      // loads and stores with base plus offset inside the 64 words
      for (int k = 0; k < MEM_COUNT; k++) begin
         rs     = 5'(rand_bits(5)) | 5'd1; // base never r0
         rt     = 5'(rand_bits(5));
         base_w = 6'(rand_bits(6));
         off_w  = 6'(rand_bits(6));
         host_write_reg(rs, {24'd0, base_w, 2'b00});
         imm = 16'((int'(off_w) - int'(base_w)) * 4);
         if (k < MEM_COUNT / 2 || rand_bits(1) == 32'd1) begin
            run_instr({SW, rs, rt, imm});
            check_dmem(off_w);
         end else begin
            run_instr({LW, rs, rt, imm});
            check_reg(rt);
         end
      end
      for (int i = 0; i < DMEM_WORDS; i++) check_dmem(6'(i));

      // branches with about half the pairs forced equal
      for (int k = 0; k < BR_COUNT; k++) begin
         rs = 5'(rand_bits(5));
         rt = 5'(rand_bits(5));
         if (rand_bits(1) == 32'd1) host_write_reg(rt, model_regs[rs]);
         op = (rand_bits(1) == 32'd1) ? BEQ : BNE;
         run_instr({op, rs, rt, 16'(rand_bits(16))});
         check_status();
      end

      // halt then a refused command and bad addresses
      run_instr({HALT, 26'd0});
      check_status();
      rt = 5'(rand_bits(5)) | 5'd1;
      run_instr({ADDIU, 5'd0, rt, 16'h1234}); // must not land
      check_reg(rt);
      apb_read(12'h040, d, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_write(12'h008, 32'h0, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_write(ADDR_STATUS, 32'h0, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_write(DMEM_BASE, 32'h0, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      check_status();

      other_errors = other_errors + monitor_errors;
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* cpu_exec_top.f */
logic/cpu_types_pkg.sv
logic/apb_host_port.sv
logic/control_unit.sv
logic/register_file.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_exec_top.sv
verification/cpu_exec_assertions.sv
verification/cpu_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_exec testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module cpu_exec_tb -f cpu_exec_top.f -o cpu_exec_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/cpu_exec_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test passed" sim.log; then
   exit 0
fi
exit 1
